//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ddr3_dfi_phy_tb
FILELIST := src.f

BUILD    := obj_dir
BINARY   := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BINARY)

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- ddr3_dfi_phy.sv
`timescale 1ns/10ps
module ddr3_dfi_phy (
  input  logic                                                          clock,
  input  logic                                                          reset,
  input  logic                                                          cfg_valid_i,
  input  logic [31:0]                                                   cfg_data_i,
  input  ddr3_phy_pkg::dfi_cmd_t                                        dfi_cmd_i,
  input  logic                                                          dfi_wren_i,
  input  logic [ddr3_phy_pkg::BEAT_COUNT-1:0][ddr3_phy_pkg::DQ_BITS-1:0] dfi_data_i,
  input  logic [ddr3_phy_pkg::BEAT_COUNT-1:0][ddr3_phy_pkg::LANE_COUNT-1:0] dfi_mask_i,
  input  logic                                                          dfi_rden_i,
  output logic                                                          dfi_valid_o,
  output logic [ddr3_phy_pkg::BEAT_COUNT-1:0][ddr3_phy_pkg::DQ_BITS-1:0] dfi_data_o,
  output ddr3_phy_pkg::dfi_cmd_t                                        ddr3_cmd_o,
  output ddr3_phy_pkg::pin_out_t                                        pin_o,
  input  ddr3_phy_pkg::pin_in_t                                         pin_i
);
  import ddr3_phy_pkg::*;

  lat_t                      rd_lat;
  lat_t                      wr_lat;
  dfi_cmd_t                  cmd_q;
  lane_rd_t [LANE_COUNT-1:0] lane_rd;

  always_ff @(posedge clock) begin
    if (reset) cmd_q <= CMD_DESELECT;
    else       cmd_q <= dfi_cmd_i;
  end

  assign ddr3_cmd_o = cmd_q;

  phy_config u_config (
    .clock      (clock),
    .reset      (reset),
    .cfg_valid_i(cfg_valid_i),
    .cfg_data_i (cfg_data_i),
    .rd_lat_o   (rd_lat),
    .wr_lat_o   (wr_lat)
  );

  for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
    lane_wr_t lane_wr;

    // This lane's byte and mask bit from each beat
    assign lane_wr = '{
      en:   dfi_wren_i,
      mask: {dfi_mask_i[1][l], dfi_mask_i[0][l]},
      beat: {dfi_data_i[1][l*LANE_BITS +: LANE_BITS], dfi_data_i[0][l*LANE_BITS +: LANE_BITS]}
    };

    phy_byte_lane u_lane (
      .clock   (clock),
      .reset   (reset),
      .wr_i    (lane_wr),
      .wr_lat_i(wr_lat),
      .pin_i   (pin_i[l]),
      .pin_o   (pin_o[l]),
      .rd_o    (lane_rd[l])
    );
  end

  phy_read_collect u_collect (
    .clock   (clock),
    .reset   (reset),
    .rden_i  (dfi_rden_i),
    .rd_lat_i(rd_lat),
    .lanes_i (lane_rd),
    .valid_o (dfi_valid_o),
    .data_o  (dfi_data_o)
  );

endmodule

//--- ddr3_dfi_phy_props.sv
`timescale 1ns/10ps
module ddr3_dfi_phy_props (
  input logic                   clock,
  input logic                   reset,
  input logic                   rden_i,
  input ddr3_phy_pkg::lat_t     rd_lat_i,
  input logic                   valid_i,
  input ddr3_phy_pkg::dfi_cmd_t cmd_i,
  input ddr3_phy_pkg::pin_out_t pin_out_i
);
  import ddr3_phy_pkg::*;

  logic [LINE_DEPTH-1:0] rden_hist;  // Bit n is rden from n+1 cycles back
  logic                  oe_any;

  always_ff @(posedge clock) begin
    if (reset) rden_hist <= '0;
    else       rden_hist <= {rden_hist[LINE_DEPTH-2:0], rden_i};
  end

  always_comb begin
    oe_any = 1'b0;
    for (int l = 0; l < LANE_COUNT; l++) oe_any = oe_any | pin_out_i[l].oe;
  end

  assert property (@(posedge clock) $past(reset) |-> (!oe_any && !cmd_i.cke && !cmd_i.reset_n
                                                      && cmd_i.cs_n))
    else $error("outputs not idle and deselected right after reset");

  // Valid trails the read enable tap at the configured latency by one register
  assert property (@(posedge clock) disable iff (reset) valid_i == rden_hist[rd_lat_i])
    else $error("dfi_valid_o out of step with delayed rden");

  for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
    assert property (@(posedge clock) disable iff (reset)
                     !pin_out_i[l].oe |-> (pin_out_i[l].beat == '0 && pin_out_i[l].mask == '0))
      else $error("lane %0d drives data or mask with oe low", l);
  end

endmodule

bind ddr3_dfi_phy ddr3_dfi_phy_props u_props (
  .clock    (clock),
  .reset    (reset),
  .rden_i   (dfi_rden_i),
  .rd_lat_i (rd_lat),
  .valid_i  (dfi_valid_o),
  .cmd_i    (ddr3_cmd_o),
  .pin_out_i(pin_o)
);

//--- ddr3_dfi_phy_tb.sv
`timescale 1ns/10ps
module ddr3_dfi_phy_tb;
  import ddr3_phy_pkg::*;

  typedef logic [BEAT_COUNT-1:0][DQ_BITS-1:0] dfi_word_t;
  typedef logic [BEAT_COUNT-1:0][LANE_COUNT-1:0] dfi_mask_t;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int CMD_CYCLES = 200;
  localparam int TRAFFIC_CYCLES = 100;
  localparam int DRAIN_CYCLES = 20;  // Longer than any read or write latency
  localparam int B2B_CYCLES = 64;
  // Five traffic blocks in tests 3 to 5, two config strobes, then a margin
  localparam int TOTAL_CYCLES = RESET_CYCLES + CMD_CYCLES
                                + 5 * (TRAFFIC_CYCLES + DRAIN_CYCLES)
                                + B2B_CYCLES + DRAIN_CYCLES + 2 + 100;

  logic      clock;
  logic      reset;
  logic      cfg_valid_i;
  logic [31:0] cfg_data_i;
  dfi_cmd_t  dfi_cmd_i;
  logic      dfi_wren_i;
  dfi_word_t dfi_data_i;
  dfi_mask_t dfi_mask_i;
  logic      dfi_rden_i;
  logic      dfi_valid_o;
  dfi_word_t dfi_data_o;
  dfi_cmd_t  ddr3_cmd_o;
  pin_out_t  pin_o;
  pin_in_t   pin_i;

  // Reference model state
  logic [31:0] lcg_state = 32'd64;
  int          cycle;
  int          errors;
  int          checks;
  int          test_count;
  int          errors_at_start;
  int          rd_lat_m = DEFAULT_RD_LAT;
  int          wr_lat_m = DEFAULT_WR_LAT;
  dfi_word_t   held;  // Beats last seen under strobe
  dfi_cmd_t    exp_cmd [int];
  pin_out_t    exp_pins [int];
  dfi_word_t   exp_data [int];
  bit          capture_at [int];

  ddr3_dfi_phy dut (
    .clock      (clock),
    .reset      (reset),
    .cfg_valid_i(cfg_valid_i),
    .cfg_data_i (cfg_data_i),
    .dfi_cmd_i  (dfi_cmd_i),
    .dfi_wren_i (dfi_wren_i),
    .dfi_data_i (dfi_data_i),
    .dfi_mask_i (dfi_mask_i),
    .dfi_rden_i (dfi_rden_i),
    .dfi_valid_o(dfi_valid_o),
    .dfi_data_o (dfi_data_o),
    .ddr3_cmd_o (ddr3_cmd_o),
    .pin_o      (pin_o),
    .pin_i      (pin_i)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD);
    $display("watchdog: simulation ran past %0d cycles without finishing", TOTAL_CYCLES);
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_cmd(input dfi_cmd_t expected);
    checks++;
    if (ddr3_cmd_o !== expected) begin
      errors++;
      $display("[ERROR] cycle %0d ddr3_cmd_o: expected %h, got %h", cycle, expected, ddr3_cmd_o);
    end
  endtask

  task automatic check_pins(input pin_out_t expected);
    checks++;
    if (pin_o !== expected) begin
      errors++;
      $display("[ERROR] cycle %0d pin_o: expected %h, got %h", cycle, expected, pin_o);
    end
  endtask

  task automatic check_read(input logic exp_valid, input dfi_word_t exp_word);
    checks++;
    if (dfi_valid_o !== exp_valid) begin
      errors++;
      $display("[ERROR] cycle %0d dfi_valid_o: expected %h, got %h", cycle, exp_valid,
               dfi_valid_o);
    end else if (exp_valid && dfi_data_o !== exp_word) begin
      errors++;
      $display("[ERROR] cycle %0d dfi_data_o: expected %h, got %h", cycle, exp_word, dfi_data_o);
    end
  endtask

  task automatic check_reset_state();
    dfi_cmd_t deselect;
    deselect = '0;
    deselect.cs_n = 1'b1;
    deselect.ras_n = 1'b1;
    deselect.cas_n = 1'b1;
    deselect.we_n = 1'b1;
    check_cmd(deselect);
    check_pins('0);
    check_read(1'b0, '0);
  endtask

  task automatic compare_outputs();
    pin_out_t exp_p;
    exp_p = '0;  // Idle bus unless a write lands here
    if (exp_pins.exists(cycle)) begin
      exp_p = exp_pins[cycle];
      exp_pins.delete(cycle);
    end
    check_pins(exp_p);
    if (exp_cmd.exists(cycle)) begin
      check_cmd(exp_cmd[cycle]);
      exp_cmd.delete(cycle);
    end
    if (exp_data.exists(cycle)) begin
      check_read(1'b1, exp_data[cycle]);
      exp_data.delete(cycle);
    end else begin
      check_read(1'b0, '0);
    end
  endtask

  // Random inputs for the current cycle, with predictions for later cycles
  task automatic drive_cycle(input int wr_pct, input int rd_pct);
    logic [31:0] r;
    dfi_cmd_t    cmd;
    dfi_word_t   wdata;
    dfi_mask_t   wmask;
    pin_in_t     pins_in;
    pin_out_t    pins_out;
    logic        wren;
    logic        rden;
    r = next_random();
    cmd = r[$bits(dfi_cmd_t)-1:0];
    wdata = next_random();
    r = next_random();
    wmask = r[$bits(dfi_mask_t)-1:0];
    wren = ((next_random() >> 8) % 100) < wr_pct;
    rden = ((next_random() >> 8) % 100) < rd_pct;
    for (int l = 0; l < LANE_COUNT; l++) begin
      r = next_random();
      pins_in[l] = r[$bits(lane_pin_in_t)-1:0];
    end

    cfg_valid_i = 1'b0;
    dfi_cmd_i = cmd;
    dfi_wren_i = wren;
    dfi_data_i = wdata;
    dfi_mask_i = wmask;
    dfi_rden_i = rden;
    pin_i = pins_in;

    exp_cmd[cycle + 1] = cmd;
    if (wren) begin
      for (int l = 0; l < LANE_COUNT; l++) begin
        pins_out[l].oe = 1'b1;
        for (int b = 0; b < BEAT_COUNT; b++) begin
          pins_out[l].mask[b] = wmask[b][l];
          pins_out[l].beat[b] = wdata[b][l*LANE_BITS +: LANE_BITS];
        end
      end
      exp_pins[cycle + wr_lat_m] = pins_out;
    end
    for (int l = 0; l < LANE_COUNT; l++) begin
      for (int b = 0; b < BEAT_COUNT; b++) begin
        if (pins_in[l].strobe[b]) held[b][l*LANE_BITS +: LANE_BITS] = pins_in[l].beat[b];
      end
    end
    if (capture_at.exists(cycle)) begin
      exp_data[cycle + 1] = held;  // Valid follows the capture cycle
      capture_at.delete(cycle);
    end
    if (rden) capture_at[cycle + rd_lat_m] = 1'b1;
  endtask

  task automatic run_cycle(input int wr_pct, input int rd_pct);
    @(posedge clock);
    cycle++;
    #1;
    compare_outputs();
    #4;
    drive_cycle(wr_pct, rd_pct);
  endtask

  task automatic run_block(input int count, input int wr_pct, input int rd_pct);
    repeat (count) run_cycle(wr_pct, rd_pct);
  endtask

  task automatic reconfigure(input lat_t rd, input lat_t wr);
    run_cycle(0, 0);
    cfg_data_i = next_random();  // Unused bits stay random
    cfg_data_i[11:8] = rd;
    cfg_data_i[15:12] = wr;
    cfg_valid_i = 1'b1;
    rd_lat_m = (rd < lat_t'(MIN_LAT)) ? MIN_LAT : int'(rd);
    wr_lat_m = (wr < lat_t'(MIN_LAT)) ? MIN_LAT : int'(wr);
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    reset = 1'b1;
    cfg_valid_i = 1'b0;
    cfg_data_i = '0;
    dfi_cmd_i = '0;
    dfi_wren_i = 1'b0;
    dfi_data_i = '0;
    dfi_mask_i = '0;
    dfi_rden_i = 1'b0;
    for (int l = 0; l < LANE_COUNT; l++) begin
      pin_i[l].strobe = '1;  // Loads known zero captures during reset
      pin_i[l].beat = '0;
    end
    held = '0;

    repeat (RESET_CYCLES) @(posedge clock);
    cycle = RESET_CYCLES;
    #1;
    check_reset_state();
    #4;
    reset = 1'b0;
    drive_cycle(0, 0);
    report_test("reset state");

    run_block(CMD_CYCLES, 0, 0);
    report_test("command pass-through");

    run_block(TRAFFIC_CYCLES, 50, 0);
    run_block(DRAIN_CYCLES, 0, 0);
    report_test("write timing");

    run_block(TRAFFIC_CYCLES, 0, 50);
    run_block(DRAIN_CYCLES, 0, 0);
    report_test("read capture");

    reconfigure(4'd7, 4'd3);
    run_block(TRAFFIC_CYCLES, 50, 0);
    run_block(DRAIN_CYCLES, 0, 0);
    run_block(TRAFFIC_CYCLES, 0, 50);
    run_block(DRAIN_CYCLES, 0, 0);
    reconfigure(4'd1, 4'd1);  // Both clamp to the minimum
    run_block(TRAFFIC_CYCLES, 40, 40);
    run_block(DRAIN_CYCLES, 0, 0);
    report_test("reconfiguration");

    run_block(B2B_CYCLES, 100, 100);
    run_block(DRAIN_CYCLES, 0, 0);
    report_test("back-to-back traffic");

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- ddr3_phy_pkg.sv
package ddr3_phy_pkg;

  // Lane and pin geometry
  localparam int LANE_COUNT = 2;
  localparam int LANE_BITS = 8;
  localparam int BEAT_COUNT = 2;  // Beats per controller clock
  localparam int DQ_BITS = LANE_COUNT * LANE_BITS;

  // Command bus
  localparam int ADDR_BITS = 14;
  localparam int BANK_BITS = 3;

  // Latency control
  localparam int LAT_BITS = 4;
  localparam int LINE_DEPTH = 16;
  localparam int MIN_LAT = 2;
  localparam int DEFAULT_RD_LAT = 4;
  localparam int DEFAULT_WR_LAT = 4;

  // Field positions in the configuration word
  localparam int CFG_RD_LSB = 8;
  localparam int CFG_WR_LSB = 12;

  typedef logic [LAT_BITS-1:0] lat_t;

  typedef struct packed {
    logic                 cke;
    logic                 reset_n;
    logic                 cs_n;
    logic                 ras_n;
    logic                 cas_n;
    logic                 we_n;
    logic                 odt;
    logic [BANK_BITS-1:0] bank;
    logic [ADDR_BITS-1:0] addr;
  } dfi_cmd_t;

  // Clock disabled, DRAM held in reset, chip deselected
  localparam dfi_cmd_t CMD_DESELECT = '{
    cke: 1'b0, reset_n: 1'b0, cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
    odt: 1'b0, bank: '0, addr: '0
  };

  typedef struct packed {
    logic                                  en;
    logic [BEAT_COUNT-1:0]                 mask;
    logic [BEAT_COUNT-1:0][LANE_BITS-1:0]  beat;
  } lane_wr_t;

  typedef struct packed {
    logic                                  oe;
    logic [BEAT_COUNT-1:0]                 mask;
    logic [BEAT_COUNT-1:0][LANE_BITS-1:0]  beat;
  } lane_pin_out_t;

  typedef struct packed {
    logic [BEAT_COUNT-1:0]                 strobe;  // Per-beat DQS valid
    logic [BEAT_COUNT-1:0][LANE_BITS-1:0]  beat;
  } lane_pin_in_t;

  typedef lane_pin_out_t [LANE_COUNT-1:0] pin_out_t;
  typedef lane_pin_in_t [LANE_COUNT-1:0] pin_in_t;

  typedef struct packed {
    logic [BEAT_COUNT-1:0][LANE_BITS-1:0] beat;
  } lane_rd_t;

endpackage

//--- latency_line.sv
`timescale 1ns/10ps
module latency_line #(
  parameter type payload_t = logic
) (
  input  logic               clock,
  input  payload_t           in_i,
  input  ddr3_phy_pkg::lat_t tap_i,
  output payload_t           out_o
);
  import ddr3_phy_pkg::*;

  // Stage n holds the input from n cycles back
  payload_t stage_q [1:LINE_DEPTH-1];

  always_ff @(posedge clock) begin
    stage_q[1] <= in_i;
    for (int i = 2; i < LINE_DEPTH; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  always_comb begin
    if (tap_i == '0) begin
      out_o = in_i;  // Zero delay bypass
    end else begin
      out_o = stage_q[tap_i];
    end
  end

endmodule

//--- phy_byte_lane.sv
`timescale 1ns/10ps
module phy_byte_lane (
  input  logic                        clock,
  input  logic                        reset,
  input  ddr3_phy_pkg::lane_wr_t      wr_i,
  input  ddr3_phy_pkg::lat_t          wr_lat_i,
  input  ddr3_phy_pkg::lane_pin_in_t  pin_i,
  output ddr3_phy_pkg::lane_pin_out_t pin_o,
  output ddr3_phy_pkg::lane_rd_t      rd_o
);
  import ddr3_phy_pkg::*;

  lat_t          wr_tap;
  lane_wr_t      wr_delayed;
  lane_pin_out_t pin_q;
  lane_rd_t      capture_d;
  lane_rd_t      capture_q;

  // Output register supplies the last cycle of write latency
  assign wr_tap = wr_lat_i - lat_t'(1);

  latency_line #(
    .payload_t(lane_wr_t)
  ) u_wr_line (
    .clock(clock),
    .in_i (wr_i),
    .tap_i(wr_tap),
    .out_o(wr_delayed)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      pin_q <= '0;
    end else if (wr_delayed.en) begin
      pin_q.oe   <= 1'b1;
      pin_q.mask <= wr_delayed.mask;
      pin_q.beat <= wr_delayed.beat;
    end else begin
      pin_q <= '0;  // Idle bus drives zero
    end
  end

  assign pin_o = pin_q;

  // Each beat only updates where its strobe was seen
  always_comb begin
    for (int b = 0; b < BEAT_COUNT; b++) begin
      if (pin_i.strobe[b]) begin
        capture_d.beat[b] = pin_i.beat[b];
      end else begin
        capture_d.beat[b] = capture_q.beat[b];
      end
    end
  end

  always_ff @(posedge clock) begin
    capture_q <= capture_d;
  end

  // Current pin cycle included, so the collector samples it with the rden tap
  assign rd_o = capture_d;

endmodule

//--- phy_config.sv
`timescale 1ns/10ps
module phy_config (
  input  logic               clock,
  input  logic               reset,
  input  logic               cfg_valid_i,
  input  logic [31:0]        cfg_data_i,
  output ddr3_phy_pkg::lat_t rd_lat_o,
  output ddr3_phy_pkg::lat_t wr_lat_o
);
  import ddr3_phy_pkg::*;

  lat_t rd_lat_q;
  lat_t wr_lat_q;
  lat_t rd_field;
  lat_t wr_field;

  // Latencies below the pipeline minimum cannot be met
  function automatic lat_t clamp_lat(input lat_t value);
    if (value < lat_t'(MIN_LAT)) begin
      return lat_t'(MIN_LAT);
    end
    return value;
  endfunction

  assign rd_field = cfg_data_i[CFG_RD_LSB +: LAT_BITS];
  assign wr_field = cfg_data_i[CFG_WR_LSB +: LAT_BITS];

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_lat_q <= lat_t'(DEFAULT_RD_LAT);
      wr_lat_q <= lat_t'(DEFAULT_WR_LAT);
    end else if (cfg_valid_i) begin
      rd_lat_q <= clamp_lat(rd_field);
      wr_lat_q <= clamp_lat(wr_field);
    end
  end

  assign rd_lat_o = rd_lat_q;
  assign wr_lat_o = wr_lat_q;

endmodule

//--- phy_read_collect.sv
`timescale 1ns/10ps
module phy_read_collect (
  input  logic                                                          clock,
  input  logic                                                          reset,
  input  logic                                                          rden_i,
  input  ddr3_phy_pkg::lat_t                                            rd_lat_i,
  input  ddr3_phy_pkg::lane_rd_t [ddr3_phy_pkg::LANE_COUNT-1:0]         lanes_i,
  output logic                                                          valid_o,
  output logic [ddr3_phy_pkg::BEAT_COUNT-1:0][ddr3_phy_pkg::DQ_BITS-1:0] data_o
);
  import ddr3_phy_pkg::*;

  logic                                rden_tap;
  logic                                valid_q;
  logic [BEAT_COUNT-1:0][DQ_BITS-1:0] data_d;
  logic [BEAT_COUNT-1:0][DQ_BITS-1:0] data_q;

  latency_line #(
    .payload_t(logic)
  ) u_rden_line (
    .clock(clock),
    .in_i (rden_i),
    .tap_i(rd_lat_i),
    .out_o(rden_tap)
  );

  // Lane bytes side by side within each beat
  always_comb begin
    for (int b = 0; b < BEAT_COUNT; b++) begin
      for (int l = 0; l < LANE_COUNT; l++) begin
        data_d[b][l*LANE_BITS +: LANE_BITS] = lanes_i[l].beat[b];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rden_tap;
    end
  end

  always_ff @(posedge clock) begin
    if (rden_tap) data_q <= data_d;  // Hold between reads
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

//--- src.f
ddr3_phy_pkg.sv
latency_line.sv
phy_config.sv
phy_byte_lane.sv
phy_read_collect.sv
ddr3_dfi_phy.sv
ddr3_dfi_phy_props.sv
ddr3_dfi_phy_tb.sv
